// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = imuldiv_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: imuldiv_cfg.svh
//----------------------------------------------------------
// multiply/divide unit configuration
// operand width, function codes, iteration counter
//----------------------------------------------------------

`ifndef IMULDIV_CFG_SVH
`define IMULDIV_CFG_SVH

// operand width, the result is twice this
`define IMULDIV_XLEN 32

// function code field
`define IMULDIV_FN_W    2
`define IMULDIV_FN_MUL  2'd0
`define IMULDIV_FN_DIV  2'd1
`define IMULDIV_FN_DIVU 2'd2

// iteration counter, one step per operand bit
`define IMULDIV_CNT_W 5

`endif

// File: imuldiv_chk.sv
//----------------------------------------------------------
// handshake checker for the multiply/divide unit
// bound into the top level, concurrent assertions only
//----------------------------------------------------------

module imuldiv_chk (
  input logic                clk,
  input logic                reset,
  input logic                req_val,
  input logic                req_rdy,
  input logic                mul_op_val,
  input logic                mul_op_rdy,
  input logic                div_op_val,
  input logic                div_op_rdy,
  input logic                mul_res_val,
  input logic                div_res_val,
  input logic                resp_val,
  input logic                resp_rdy,
  input imuldiv_pkg::dword_t resp
);

  logic buf_full;

  // decode buffer occupancy rebuilt from the handshakes around it
  always_ff @(posedge clk) begin
    if (reset)
      buf_full <= 1'b0;
    else if (req_val && req_rdy)
      buf_full <= 1'b1;
    else if ((mul_op_val && mul_op_rdy) || (div_op_val && div_op_rdy))
      buf_full <= 1'b0;
  end

  // stalled response keeps its value
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp)))
    else $error("response changed or dropped while stalled");

  // one execute block busy at a time
  res_excl: assert property (@(posedge clk) disable iff (reset)
    !(mul_res_val && div_res_val))
    else $error("both execute blocks offer a result");

  resp_after_reset: assert property (@(posedge clk) reset |=> !resp_val)
    else $error("resp_val high right after reset");

  req_rdy_low: assert property (@(posedge clk) disable iff (reset)
    !req_rdy |-> buf_full)
    else $error("req_rdy low with the decode buffer empty");

endmodule

// File: imuldiv_decode.sv
//----------------------------------------------------------
// request decode, one-entry buffer
// makes magnitudes and negate flags, issues in order
//----------------------------------------------------------

`include "imuldiv_cfg.svh"

module imuldiv_decode (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_val,
  output logic                   req_rdy,
  input  imuldiv_pkg::muldiv_req_t req,
  output logic                   mul_op_val,
  input  logic                   mul_op_rdy,
  output logic                   div_op_val,
  input  logic                   div_op_rdy,
  output imuldiv_pkg::exec_op_t  op
);

  logic                  full;
  logic                  issue;
  logic                  signed_op;
  logic                  sign_a;
  logic                  sign_b;
  imuldiv_pkg::exec_op_t op_q;
  imuldiv_pkg::exec_op_t op_d;

  // unsigned divide keeps raw operands
  assign signed_op = (req.fn != `IMULDIV_FN_DIVU);
  assign sign_a    = signed_op & req.a[`IMULDIV_XLEN-1];
  assign sign_b    = signed_op & req.b[`IMULDIV_XLEN-1];

  always_comb begin
    op_d.mag_a  = sign_a ? (~req.a + 1'b1) : req.a;
    op_d.mag_b  = sign_b ? (~req.b + 1'b1) : req.b;
    op_d.is_mul = (req.fn == `IMULDIV_FN_MUL);
    // product sign, or quotient sign unless dividing by zero
    if (op_d.is_mul)
      op_d.neg_lo = sign_a ^ sign_b;
    else
      op_d.neg_lo = (req.fn == `IMULDIV_FN_DIV) && (sign_a ^ sign_b) && (req.b != '0);
    // remainder follows the dividend
    op_d.neg_hi = !op_d.is_mul && sign_a;
  end

  // a unit is offered work only while the other one is idle too
  assign mul_op_val = full && op_q.is_mul && div_op_rdy;
  assign div_op_val = full && !op_q.is_mul && mul_op_rdy;
  assign issue      = (mul_op_val && mul_op_rdy) || (div_op_val && div_op_rdy);

  // accept into an empty buffer or one that drains this cycle
  assign req_rdy = !full || issue;
  assign op      = op_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (req_val && req_rdy) begin
      full <= 1'b1;
    end else if (issue) begin
      full <= 1'b0;
    end
  end

  // payload only moves on accept
  always_ff @(posedge clk) begin
    if (req_val && req_rdy) begin
      op_q <= op_d;
    end
  end

endmodule

// File: imuldiv_div_iter.sv
//----------------------------------------------------------
// iterative restoring divider on magnitudes
// result is {remainder, quotient} after 32 steps
//----------------------------------------------------------

`include "imuldiv_cfg.svh"

module imuldiv_div_iter (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   op_val,
  output logic                   op_rdy,
  input  imuldiv_pkg::exec_op_t  op,
  output logic                   res_val,
  input  logic                   res_rdy,
  output imuldiv_pkg::exec_res_t res
);

  imuldiv_pkg::iter_state_t state;
  imuldiv_pkg::iter_state_t state_next;
  imuldiv_pkg::cnt_t        cnt;
  logic                     ld;
  logic                     step;
  logic                     last;

  // remainder in the upper word, quotient shifts in below
  imuldiv_pkg::dword_t      rq;
  imuldiv_pkg::word_t       divisor;
  logic [`IMULDIV_XLEN:0]   diff;
  logic                     neg_lo;
  logic                     neg_hi;
  logic                     is_mul;

  assign last = (cnt == {`IMULDIV_CNT_W{1'b1}});

  //----------------------------------------------------------
  // control
  //----------------------------------------------------------

  always_comb begin
    state_next = state;
    op_rdy     = 1'b0;
    res_val    = 1'b0;
    ld         = 1'b0;
    step       = 1'b0;
    case (state)
      imuldiv_pkg::IDLE: begin
        op_rdy = 1'b1;
        ld     = op_val;
        if (op_val)
          state_next = imuldiv_pkg::CALC;
      end
      imuldiv_pkg::CALC: begin
        step = 1'b1;
        if (last)
          state_next = imuldiv_pkg::DONE;
      end
      imuldiv_pkg::DONE: begin
        res_val = 1'b1;
        if (res_rdy)
          state_next = imuldiv_pkg::IDLE;
      end
      default: state_next = imuldiv_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::IDLE;
      cnt   <= '0;
    end else begin
      state <= state_next;
      if (ld)
        cnt <= '0;
      else if (step)
        cnt <= cnt + 1'b1;
    end
  end

  //----------------------------------------------------------
  // datapath
  //----------------------------------------------------------

  // trial subtract on the shifted remainder, 33 bits
  // remainder stays below the divisor, so bit 32 is the borrow
  assign diff = rq[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN-1] - {1'b0, divisor};

  always_ff @(posedge clk) begin
    if (ld) begin
      rq      <= {{`IMULDIV_XLEN{1'b0}}, op.mag_a};
      divisor <= op.mag_b;
      neg_lo  <= op.neg_lo;
      neg_hi  <= op.neg_hi;
      is_mul  <= op.is_mul;
    end else if (step) begin
      if (diff[`IMULDIV_XLEN])
        // negative, restore by keeping the plain shift
        rq <= {rq[2*`IMULDIV_XLEN-2:0], 1'b0};
      else
        rq <= {diff[`IMULDIV_XLEN-1:0], rq[`IMULDIV_XLEN-2:0], 1'b1};
    end
  end

  // zero divisor never borrows: all-ones quotient, dividend as remainder
  assign res = '{raw: rq, neg_lo: neg_lo, neg_hi: neg_hi, is_mul: is_mul};

endmodule

// File: imuldiv_golden.txt
// per line fn, operand a, operand b, expected 64-bit result
// fn 0 multiply, 1 signed divide, 2 unsigned divide with {remainder, quotient}
0 00000003 00000007 0000000000000015
0 fffffffd 00000007 ffffffffffffffeb
0 00000003 fffffff9 ffffffffffffffeb
0 fffffffd fffffff9 0000000000000015
0 80000000 80000000 4000000000000000
0 7fffffff 7fffffff 3fffffff00000001
0 80000000 7fffffff c000000080000000
0 12345678 00000010 0000000123456780
0 ffffffff ffffffff 0000000000000001
0 00000000 80000000 0000000000000000
2 ffffffff 00000010 0000000f0fffffff
2 80000000 00000003 000000022aaaaaaa
2 fffffffe ffffffff fffffffe00000000
2 ffffffff 80000000 7fffffff00000001
2 87654321 00001000 0000032100087654
1 00000007 00000002 0000000100000003
1 fffffff9 00000002 fffffffffffffffd
1 00000007 fffffffe 00000001fffffffd
1 fffffff9 fffffffe ffffffff00000003
1 ffffff9c 00000007 fffffffefffffff2
1 00000005 00000000 00000005ffffffff
1 fffffff9 00000000 fffffff9ffffffff
2 deadbeef 00000000 deadbeefffffffff
1 80000000 ffffffff 0000000080000000
1 80000000 00000001 0000000080000000
0 00010000 00010000 0000000100000000
2 00000064 00000007 000000020000000e
1 80000001 00000002 ffffffffc0000001
0 deadbeef 00000002 ffffffffbd5b7dde
2 00000000 00000005 0000000000000000

// File: imuldiv_mul_iter.sv
//----------------------------------------------------------
// iterative shift-add multiplier on magnitudes
// 32 steps, one multiplier bit per cycle
//----------------------------------------------------------

`include "imuldiv_cfg.svh"

module imuldiv_mul_iter (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   op_val,
  output logic                   op_rdy,
  input  imuldiv_pkg::exec_op_t  op,
  output logic                   res_val,
  input  logic                   res_rdy,
  output imuldiv_pkg::exec_res_t res
);

  imuldiv_pkg::iter_state_t state;
  imuldiv_pkg::iter_state_t state_next;
  imuldiv_pkg::cnt_t        cnt;
  logic                     ld;
  logic                     step;
  logic                     last;

  // datapath registers
  imuldiv_pkg::dword_t mcand;
  imuldiv_pkg::word_t  mplier;
  imuldiv_pkg::dword_t prod;
  logic                neg_lo;
  logic                neg_hi;
  logic                is_mul;

  assign last = (cnt == {`IMULDIV_CNT_W{1'b1}});

  //----------------------------------------------------------
  // control
  //----------------------------------------------------------

  always_comb begin
    state_next = state;
    op_rdy     = 1'b0;
    res_val    = 1'b0;
    ld         = 1'b0;
    step       = 1'b0;
    case (state)
      imuldiv_pkg::IDLE: begin
        op_rdy = 1'b1;
        ld     = op_val;
        if (op_val)
          state_next = imuldiv_pkg::CALC;
      end
      imuldiv_pkg::CALC: begin
        step = 1'b1;
        // 32nd step ends the run
        if (last)
          state_next = imuldiv_pkg::DONE;
      end
      imuldiv_pkg::DONE: begin
        res_val = 1'b1;
        if (res_rdy)
          state_next = imuldiv_pkg::IDLE;
      end
      default: state_next = imuldiv_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::IDLE;
      cnt   <= '0;
    end else begin
      state <= state_next;
      if (ld)
        cnt <= '0;
      else if (step)
        cnt <= cnt + 1'b1;
    end
  end

  //----------------------------------------------------------
  // datapath
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (ld) begin
      mcand  <= {{`IMULDIV_XLEN{1'b0}}, op.mag_a};
      mplier <= op.mag_b;
      prod   <= '0;
      neg_lo <= op.neg_lo;
      neg_hi <= op.neg_hi;
      is_mul <= op.is_mul;
    end else if (step) begin
      // add the shifted multiplicand when the low bit is set
      if (mplier[0])
        prod <= prod + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // flags pass through untouched
  assign res = '{raw: prod, neg_lo: neg_lo, neg_hi: neg_hi, is_mul: is_mul};

endmodule

// File: imuldiv_pkg.sv
//----------------------------------------------------------
// multiply/divide unit shared types
// width typedefs, message structs, iteration states
//----------------------------------------------------------

`include "imuldiv_cfg.svh"

package imuldiv_pkg;

  // plain vectors with a meaning
  typedef logic [`IMULDIV_XLEN-1:0]   word_t;
  typedef logic [2*`IMULDIV_XLEN-1:0] dword_t;
  typedef logic [`IMULDIV_FN_W-1:0]   fn_t;
  typedef logic [`IMULDIV_CNT_W-1:0]  cnt_t;

  // request from the processor
  typedef struct packed {
    fn_t   fn;
    word_t a;
    word_t b;
  } muldiv_req_t;

  // magnitudes plus the sign fixups to apply at the end
  typedef struct packed {
    word_t mag_a;
    word_t mag_b;
    logic  neg_lo;
    logic  neg_hi;
    logic  is_mul;
  } exec_op_t;

  // unsigned product, or {remainder, quotient}
  typedef struct packed {
    dword_t raw;
    logic   neg_lo;
    logic   neg_hi;
    logic   is_mul;
  } exec_res_t;

  // control states of both execute blocks
  typedef enum logic [1:0] {IDLE, CALC, DONE} iter_state_t;

endpackage

// File: imuldiv_result.sv
//----------------------------------------------------------
// result stage: sign correction and response register
// holds the response under back-pressure
//----------------------------------------------------------

`include "imuldiv_cfg.svh"

module imuldiv_result (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   mul_res_val,
  output logic                   mul_res_rdy,
  input  imuldiv_pkg::exec_res_t mul_res,
  input  logic                   div_res_val,
  output logic                   div_res_rdy,
  input  imuldiv_pkg::exec_res_t div_res,
  output logic                   resp_val,
  input  logic                   resp_rdy,
  output imuldiv_pkg::dword_t    resp
);

  logic                   accept;
  logic                   load;
  imuldiv_pkg::exec_res_t sel;
  imuldiv_pkg::word_t     hi;
  imuldiv_pkg::word_t     lo;
  imuldiv_pkg::dword_t    fixed;

  // room when empty or draining this cycle
  assign accept = !resp_val || resp_rdy;

  // multiplier wins, the ordering rule keeps them apart anyway
  assign mul_res_rdy = accept;
  assign div_res_rdy = accept && !mul_res_val;
  assign load        = (mul_res_val && mul_res_rdy) || (div_res_val && div_res_rdy);

  assign sel = mul_res_val ? mul_res : div_res;

  // divide halves negate on their own flags
  assign hi = sel.neg_hi ? (~sel.raw[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN] + 1'b1)
                         : sel.raw[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN];
  assign lo = sel.neg_lo ? (~sel.raw[`IMULDIV_XLEN-1:0] + 1'b1)
                         : sel.raw[`IMULDIV_XLEN-1:0];

  always_comb begin
    if (sel.is_mul)
      // product negates as one 64-bit value
      fixed = sel.neg_lo ? (~sel.raw + 1'b1) : sel.raw;
    else
      fixed = {hi, lo};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (load) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      resp <= fixed;
    end
  end

endmodule

// File: imuldiv_tb.sv
//----------------------------------------------------------
// testbench for the iterative multiply/divide unit
// golden vectors in, random response stalls, ordered checks
//----------------------------------------------------------

`include "imuldiv_cfg.svh"

module imuldiv_tb;

  localparam int NUM_VEC   = 30;
  localparam int WORDS     = 4;
  localparam int RESET_CYC = 8;
  localparam int LIMIT_CYC = NUM_VEC * 80 + RESET_CYC;

  logic                     clk;
  logic                     reset;
  logic                     req_val;
  logic                     req_rdy;
  imuldiv_pkg::muldiv_req_t req;
  logic                     resp_val;
  logic                     resp_rdy;
  imuldiv_pkg::dword_t      resp;

  // four entries per vector, fn then a, b and the expected result
  logic [2*`IMULDIV_XLEN-1:0] golden [0:WORDS*NUM_VEC-1];

  integer seed;
  integer gap_seed;
  int     errors;
  int     checked;
  logic   reset_done;

  imuldiv_top dut (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req      (req),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

  // handshake checker sits inside the top level
  bind imuldiv_top imuldiv_chk chk (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .mul_op_val  (mul_op_val),
    .mul_op_rdy  (mul_op_rdy),
    .div_op_val  (div_op_val),
    .div_op_rdy  (div_op_rdy),
    .mul_res_val (mul_res_val),
    .div_res_val (div_res_val),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp        (resp)
  );

  //----------------------------------------------------------
  // helpers
  //----------------------------------------------------------

  // put vector idx on the request port
  task automatic present_request(input int idx);
    req_val <= 1'b1;
    req     <= '{fn: golden[WORDS*idx][`IMULDIV_FN_W-1:0],
                 a:  golden[WORDS*idx+1][`IMULDIV_XLEN-1:0],
                 b:  golden[WORDS*idx+2][`IMULDIV_XLEN-1:0]};
  endtask

  // compare one transferring response with the next vector in order
  task automatic check_response();
    logic [2*`IMULDIV_XLEN-1:0] expected;
    // every response needs a request still waiting for it
    assert (checked < NUM_VEC) else begin
      $display("ERROR at %0t: response arrived with no request left, resp=%h",
               $time, resp);
      errors++;
    end
    if (checked < NUM_VEC) begin
      expected = golden[WORDS*checked+3];
      assert (resp === expected) else begin
        $display("ERROR at %0t: vector %0d fn=%0d a=%h b=%h resp=%h expected=%h",
                 $time, checked, golden[WORDS*checked][`IMULDIV_FN_W-1:0],
                 golden[WORDS*checked+1][`IMULDIV_XLEN-1:0],
                 golden[WORDS*checked+2][`IMULDIV_XLEN-1:0], resp, expected);
        errors++;
      end
      checked++;
    end
  endtask

  task automatic print_summary();
    $display("errors: %0d, vectors checked: %0d of %0d", errors, checked, NUM_VEC);
  endtask

  //----------------------------------------------------------
  // clock, reset and the end of the run
  //----------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    reset      = 1'b1;
    req_val    = 1'b0;
    req        = '0;
    resp_rdy   = 1'b0;
    seed       = 82;
    errors     = 0;
    checked    = 0;
    reset_done = 1'b0;
    $readmemh("imuldiv_golden.txt", golden);
    // idle gaps get their own stream, derived from the main seed
    gap_seed = $random(seed);
    repeat (RESET_CYC) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    // nothing in flight straight out of reset
    assert (!resp_val && req_rdy) else begin
      $display("ERROR at %0t: state after reset wrong, resp_val=%b req_rdy=%b",
               $time, resp_val, req_rdy);
      errors++;
    end
    reset_done = 1'b1;
    wait (checked == NUM_VEC);
    // window for a stray extra response
    repeat (40) @(posedge clk);
    print_summary();
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  //----------------------------------------------------------
  // request driver and response receiver
  //----------------------------------------------------------

  initial begin : drive
    int gap;
    wait (reset_done);
    for (int i = 0; i < NUM_VEC; i++) begin
      gap = $random(gap_seed) & 3;
      repeat (gap) begin
        @(posedge clk);
        req_val <= 1'b0;
      end
      @(posedge clk);
      present_request(i);
      // req_rdy is registered state only, so it is settled here
      @(negedge clk);
      while (!req_rdy) @(negedge clk);
    end
    // the next edge completes the last transfer
    @(posedge clk);
    req_val <= 1'b0;
  end

  initial begin : receive
    wait (reset_done);
    forever begin
      @(posedge clk);
      // ready about three cycles in four
      resp_rdy <= (($random(seed) & 3) != 0);
      @(negedge clk);
      if (resp_val && resp_rdy)
        check_response();
    end
  end

  initial begin : watchdog
    repeat (LIMIT_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles, responses stopped arriving", LIMIT_CYC);
    print_summary();
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: imuldiv_top.sv
//----------------------------------------------------------
// iterative multiply/divide unit, top level
// decode, shift-add multiplier, restoring divider, result
//----------------------------------------------------------

`include "imuldiv_cfg.svh"

module imuldiv_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_val,
  output logic                    req_rdy,
  input  imuldiv_pkg::muldiv_req_t req,
  output logic                    resp_val,
  input  logic                    resp_rdy,
  output imuldiv_pkg::dword_t     resp
);

  // decode to execute, op shared by both units
  logic                   mul_op_val;
  logic                   mul_op_rdy;
  logic                   div_op_val;
  logic                   div_op_rdy;
  imuldiv_pkg::exec_op_t  op;

  // execute to result
  logic                   mul_res_val;
  logic                   mul_res_rdy;
  imuldiv_pkg::exec_res_t mul_res;
  logic                   div_res_val;
  logic                   div_res_rdy;
  imuldiv_pkg::exec_res_t div_res;

  imuldiv_decode decode (
    .clk        (clk),
    .reset      (reset),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .req        (req),
    .mul_op_val (mul_op_val),
    .mul_op_rdy (mul_op_rdy),
    .div_op_val (div_op_val),
    .div_op_rdy (div_op_rdy),
    .op         (op)
  );

  imuldiv_mul_iter mul_iter (
    .clk     (clk),
    .reset   (reset),
    .op_val  (mul_op_val),
    .op_rdy  (mul_op_rdy),
    .op      (op),
    .res_val (mul_res_val),
    .res_rdy (mul_res_rdy),
    .res     (mul_res)
  );

  imuldiv_div_iter div_iter (
    .clk     (clk),
    .reset   (reset),
    .op_val  (div_op_val),
    .op_rdy  (div_op_rdy),
    .op      (op),
    .res_val (div_res_val),
    .res_rdy (div_res_rdy),
    .res     (div_res)
  );

  imuldiv_result result (
    .clk         (clk),
    .reset       (reset),
    .mul_res_val (mul_res_val),
    .mul_res_rdy (mul_res_rdy),
    .mul_res     (mul_res),
    .div_res_val (div_res_val),
    .div_res_rdy (div_res_rdy),
    .div_res     (div_res),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp        (resp)
  );

endmodule

// File: vlog.f
+incdir+.
imuldiv_pkg.sv
imuldiv_decode.sv
imuldiv_mul_iter.sv
imuldiv_div_iter.sv
imuldiv_result.sv
imuldiv_top.sv
imuldiv_chk.sv
imuldiv_tb.sv
